/* filelist.f */
src/nes_bus_pkg.sv
src/clock_enables.sv
src/dma_sequencer.sv
src/bus_decoder.sv
src/nes_dma_bus.sv
verification/nes_dma_bus_chk.sv
verification/nes_dma_bus_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps --top-module nes_dma_bus_tb \
	-Mdir obj_dir -o nes_dma_bus_tb -f filelist.f &&
./obj_dir/nes_dma_bus_tb ||
{ echo "simulation did not complete cleanly" >&2; exit 1; }

/* src/bus_decoder.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU/DMA bus mux, APU and PPU selects, read data steering,
// open bus latch and joypad strobe/clock generation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::cpu_addr_u cpu_addr,
	input  logic [7:0]            cpu_dout,
	input  logic                  cpu_rnw,
	input  logic                  dma_enable,
	input  logic                  dma_read,
	input  nes_bus_pkg::cpu_addr_u dma_addr,
	input  logic [7:0]            dma_dout,
	input  logic [7:0]            mem_din,
	input  logic [7:0]            ppu_dout,
	input  logic [7:0]            apu_status,
	input  logic [4:0]            joypad1_data,
	input  logic [4:0]            joypad2_data,
	output nes_bus_pkg::cpu_addr_u bus_addr,
	output logic [7:0]            bus_dout,
	output logic                  bus_read,
	output logic                  bus_write,
	output logic                  apu_cs,
	output logic                  ppu_cs,
	output logic [7:0]            cpu_din,
	output logic [2:0]            joypad_out,   // Strobe bits from 0x4016 writes
	output logic [1:0]            joypad_clock  // Bit 0 = pad 1, bit 1 = pad 2
);
	import nes_bus_pkg::*;

	logic [7:0] open_bus;   // Last value seen on the data bus
	logic       joypad1_cs;
	logic       joypad2_cs;

	// DMA takes the bus outright whenever it asks
	assign bus_addr  = dma_enable ? dma_addr : cpu_addr;
	assign bus_dout  = dma_enable ? dma_dout : cpu_dout;
	assign bus_read  = dma_enable ? dma_read : cpu_rnw;
	assign bus_write = dma_enable ? !dma_read : !cpu_rnw;

	// Chip selects
	assign apu_cs = (bus_addr >= apu_base) && (bus_addr < apu_limit);
	assign ppu_cs = (bus_addr.rg.region == ppu_region);   // 0x2000-0x3fff, mirrored

	// Joypads sit inside the APU window
	assign joypad1_cs = (bus_addr == joypad1_addr);
	assign joypad2_cs = (bus_addr == joypad2_addr);
	assign joypad_clock = {joypad2_cs && bus_read, joypad1_cs && bus_read};

	// Read data back to the CPU
	always_comb begin
		if (reset) begin
			cpu_din = 8'h00;
		end else if (apu_cs) begin
			if (joypad1_cs)
				cpu_din = {open_bus[7:5], joypad1_data}; // Upper bits float
			else if (joypad2_cs)
				cpu_din = {open_bus[7:5], joypad2_data};
			else if (bus_addr == apu_status_addr)
				cpu_din = apu_status;
			else
				cpu_din = open_bus;                     // Write-only APU regs
		end else if (ppu_cs) begin
			cpu_din = ppu_dout;
		end else begin
			cpu_din = mem_din;
		end
	end

	// Bus capacitance holds the previous value
	always_ff @(posedge clk) begin
		open_bus <= cpu_din;
	end

	// Joypad strobe latch
	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'b000;
		else if (joypad1_cs && bus_write)
			joypad_out <= bus_dout[2:0];    // Bit 0 strobes both pads
	end

endmodule

`default_nettype wire

/* src/clock_enables.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master clock divider for CPU and PPU clock enables
// plus the odd/even CPU cycle phase used by DMA
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module clock_enables (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clock wide, every 12 clocks
	output logic ppu_ce,    // One clock wide, every 4 clocks
	output logic odd_cycle  // 1 = odd CPU cycle
);
	import nes_bus_pkg::*;

	logic [cpu_cnt_w-1:0] cpu_cnt;
	logic [ppu_cnt_w-1:0] ppu_cnt;

	// Enables fire on the last count of each period
	assign cpu_ce = (cpu_cnt == cpu_cnt_w'(cpu_div - 1));
	assign ppu_ce = (ppu_cnt == ppu_cnt_w'(ppu_div - 1));

	// CPU divider
	always_ff @(posedge clk) begin
		if (reset)
			cpu_cnt <= '0;
		else if (cpu_ce)
			cpu_cnt <= '0;                          // Wrap
		else
			cpu_cnt <= cpu_cnt + cpu_cnt_w'(1);
	end

	// PPU divider, free running beside the CPU one
	always_ff @(posedge clk) begin
		if (reset)
			ppu_cnt <= '0;
		else if (ppu_ce)
			ppu_cnt <= '0;
		else
			ppu_cnt <= ppu_cnt + ppu_cnt_w'(1);
	end

	// First CPU cycle after reset counts as odd
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b1;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;                // Flip at end of each CPU cycle
	end

endmodule

`default_nettype wire

/* src/dma_sequencer.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite (OAM) DMA and DMC sample DMA sequencer
// Pauses the CPU and takes the bus in read/write pairs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  odd_cycle,
	input  logic                  cpu_rnw,      // CPU read cycle when high
	input  nes_bus_pkg::cpu_addr_u cpu_addr,
	input  logic [7:0]            cpu_dout,     // Page number on a 0x4014 write
	input  logic [7:0]            mem_din,
	input  logic                  dmc_request,  // Held until dmc_ack
	input  nes_bus_pkg::cpu_addr_u dmc_addr,
	output logic                  dma_enable,   // DMA owns the bus
	output logic                  dma_read,
	output nes_bus_pkg::cpu_addr_u dma_addr,
	output logic [7:0]            dma_dout,
	output logic                  dmc_ack,
	output logic                  pause_cpu
);
	import nes_bus_pkg::*;

	logic [1:0] spr_state;
	logic       dmc_state;      // DMC accepted, waiting for its even slot
	cpu_addr_u  sprite_src;     // Source pointer, page:offset
	logic [7:0] sprite_data;    // Byte read on the even cycle
	logic [8:0] next_offset;    // Carry out flags the last byte
	logic       sprite_trigger;

	// Only a CPU write starts a transfer, and only from idle
	assign sprite_trigger = !cpu_rnw && (cpu_addr == oam_dma_addr) &&
		(spr_state == spr_idle);

	assign next_offset = {1'b0, sprite_src.pg.offset} + 9'd1;

	// DMC byte goes out on an even cycle, always a read
	assign dmc_ack    = dmc_state && !odd_cycle;
	assign dma_enable = dmc_ack || (spr_state == spr_active);
	assign pause_cpu  = (spr_state != spr_idle) || dmc_request; // Pending or running
	assign dma_read   = !odd_cycle;     // Reads on even, writes on odd
	assign dma_dout   = sprite_data;

	// Address select, DMC has priority over the sprite read
	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = sprite_src;
		else
			dma_addr = oam_data_addr;
	end

	// Control state, one step per CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= spr_idle;
			dmc_state <= 1'b0;
		end else if (cpu_ce) begin
			if (!dmc_state && dmc_request && cpu_rnw && !odd_cycle)
				dmc_state <= 1'b1;                  // Accept on even read cycle
			else if (dmc_ack)
				dmc_state <= 1'b0;                  // Done after one access

			case (spr_state)
				spr_idle: begin
					if (sprite_trigger)
						spr_state <= spr_pending;
				end
				spr_pending: begin
					if (cpu_rnw && odd_cycle)
						spr_state <= spr_active;        // Aligned, reads start on even
				end
				spr_active: begin
					if (dmc_ack)
						spr_state <= spr_pending;       // Lost the read slot, realign
					else if (odd_cycle && next_offset[8])
						spr_state <= spr_idle;          // Wrote offset 255
				end
				default: spr_state <= spr_idle;
			endcase
		end
	end

	// Source pointer and data latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				sprite_src.pg.page   <= cpu_dout;
				sprite_src.pg.offset <= 8'h00;
			end
			if (spr_state == spr_active && odd_cycle)
				sprite_src.pg.offset <= next_offset[7:0]; // Step after each write
			if (spr_state == spr_active && !odd_cycle && !dmc_ack)
				sprite_data <= mem_din;
		end
	end

endmodule

`default_nettype wire

/* src/nes_bus_pkg.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Console bus package with divider periods, register addresses,
// DMA sequencer state codes and the decoded CPU address word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package nes_bus_pkg;

	// Master clock dividers
	localparam int cpu_div = 12;                     // 12 master clocks per CPU cycle
	localparam int ppu_div = 4;                      // 4 master clocks per PPU dot
	localparam int cpu_cnt_w = $clog2(cpu_div);
	localparam int ppu_cnt_w = $clog2(ppu_div);

	// Memory-mapped registers
	localparam logic [15:0] oam_dma_addr    = 16'h4014; // Sprite DMA page register
	localparam logic [15:0] oam_data_addr   = 16'h2004; // OAM data port, DMA target
	localparam logic [15:0] apu_status_addr = 16'h4015;
	localparam logic [15:0] joypad1_addr    = 16'h4016; // Read pad 1, write strobe
	localparam logic [15:0] joypad2_addr    = 16'h4017;

	// APU window, upper bound exclusive
	localparam logic [15:0] apu_base  = 16'h4000;
	localparam logic [15:0] apu_limit = 16'h4018;

	// PPU registers live in 0x2000-0x3fff
	localparam logic [2:0] ppu_region = 3'd1;

	// Sprite DMA state, bit 0 = pause, bit 1 = owns bus
	localparam logic [1:0] spr_idle    = 2'b00;
	localparam logic [1:0] spr_pending = 2'b01; // Waiting for odd read cycle
	localparam logic [1:0] spr_active  = 2'b11; // Read/write pairs running

	// One CPU address, two decodes
	typedef union packed {
		struct packed {
			logic [7:0] page;   // High byte, sprite source page
			logic [7:0] offset; // Low byte, stepped by DMA
		} pg;
		struct packed {
			logic [2:0]  region; // Top bits pick the 8K region
			logic [12:0] rest;
		} rg;
	} cpu_addr_u;

endpackage

`default_nettype wire

/* src/nes_dma_bus.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA and bus section top, clock enables feed the DMA
// sequencer which feeds the bus decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module nes_dma_bus (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::cpu_addr_u cpu_addr,
	input  logic [7:0]            cpu_dout,
	input  logic                  cpu_rnw,
	input  logic                  dmc_request,
	input  nes_bus_pkg::cpu_addr_u dmc_addr,
	input  logic [7:0]            mem_din,      // External memory read data
	input  logic [7:0]            ppu_dout,
	input  logic [7:0]            apu_status,
	input  logic [4:0]            joypad1_data,
	input  logic [4:0]            joypad2_data,
	output logic                  cpu_ce,
	output logic                  ppu_ce,
	output logic                  odd_cycle,
	output logic                  pause_cpu,
	output logic                  dmc_ack,
	output nes_bus_pkg::cpu_addr_u bus_addr,
	output logic [7:0]            bus_dout,
	output logic                  bus_read,
	output logic                  bus_write,
	output logic                  apu_cs,
	output logic                  ppu_cs,
	output logic [7:0]            cpu_din,
	output logic [2:0]            joypad_out,
	output logic [1:0]            joypad_clock
);
	import nes_bus_pkg::*;

	// DMA side of the bus mux
	logic       dma_enable;
	logic       dma_read;
	cpu_addr_u  dma_addr;
	logic [7:0] dma_dout;

	clock_enables clock_enables_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.odd_cycle (odd_cycle)
	);

	// Sprite bytes come straight from memory, not the steered bus
	dma_sequencer dma_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.cpu_rnw     (cpu_rnw),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.mem_din     (mem_din),
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.dma_enable  (dma_enable),
		.dma_read    (dma_read),
		.dma_addr    (dma_addr),
		.dma_dout    (dma_dout),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

	bus_decoder bus_decoder_i (
		.clk          (clk),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.cpu_rnw      (cpu_rnw),
		.dma_enable   (dma_enable),
		.dma_read     (dma_read),
		.dma_addr     (dma_addr),
		.dma_dout     (dma_dout),
		.mem_din      (mem_din),
		.ppu_dout     (ppu_dout),
		.apu_status   (apu_status),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.bus_addr     (bus_addr),
		.bus_dout     (bus_dout),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.apu_cs       (apu_cs),
		.ppu_cs       (ppu_cs),
		.cpu_din      (cpu_din),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

`default_nettype wire

/* verification/nes_dma_bus_chk.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus protocol assertions bound into the DMA and bus top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module nes_dma_bus_chk (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic ppu_ce,
	input logic dmc_ack,
	input logic dma_enable,    // Internal mux select of the top
	input logic bus_read,
	input logic bus_write
);
	timeunit 1ns;
	timeprecision 100ps;
	import nes_bus_pkg::*;

	logic [3:0] clocks_out_of_reset;   // Saturates, only the first few clocks matter

	always_ff @(posedge clk) begin
		if (reset)
			clocks_out_of_reset <= '0;
		else if (clocks_out_of_reset != 4'hf)
			clocks_out_of_reset <= clocks_out_of_reset + 4'd1;
	end

	// DMC byte is always a DMA read
	dmc_ack_owns_bus: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> (dma_enable && bus_read))
		else $error("dmc_ack high without a DMA read on the bus");

	no_read_and_write: assert property (@(posedge clk) disable iff (reset)
		!(bus_write && bus_read))
		else $error("bus_read and bus_write high together");

	// Dividers start from zero, first pulses come late
	ppu_ce_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		(clocks_out_of_reset < 4'(ppu_div - 1)) |-> !ppu_ce)
		else $error("ppu_ce pulsed too early after reset");

	cpu_ce_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		(clocks_out_of_reset < 4'(cpu_div - 1)) |-> !cpu_ce)
		else $error("cpu_ce pulsed too early after reset");

endmodule

`default_nettype wire

/* verification/nes_dma_bus_tb.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the DMA and bus section with a
// memory model whose byte is low address XOR high address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module nes_dma_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import nes_bus_pkg::*;

	// Two sprite DMAs take about 520 CPU cycles each, the rest is short
	localparam int watchdog_cycles = 1500;
	localparam int watchdog_ns = watchdog_cycles * cpu_div * 100;

	logic       clk;
	logic       reset;
	cpu_addr_u  cpu_addr;
	logic [7:0] cpu_dout;
	logic       cpu_rnw;
	logic       dmc_request;
	cpu_addr_u  dmc_addr;
	logic [7:0] mem_din;
	logic [7:0] ppu_dout;
	logic [7:0] apu_status;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       odd_cycle;
	logic       pause_cpu;
	logic       dmc_ack;
	cpu_addr_u  bus_addr;
	logic [7:0] bus_dout;
	logic       bus_read;
	logic       bus_write;
	logic       apu_cs;
	logic       ppu_cs;
	logic [7:0] cpu_din;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	nes_dma_bus nes_dma_bus_i (.*);

	bind nes_dma_bus nes_dma_bus_chk nes_dma_bus_chk_i (
		.clk        (clk),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.ppu_ce     (ppu_ce),
		.dmc_ack    (dmc_ack),
		.dma_enable (dma_enable),
		.bus_read   (bus_read),
		.bus_write  (bus_write)
	);

	always #50 clk = ~clk;   // 100 ns master clock

	// External memory content rule
	function automatic logic [7:0] model_byte(input logic [15:0] addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	assign mem_din = model_byte(bus_addr);   // Memory answers whatever is on the bus

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic next_drive_point();
		@(posedge clk);
		#10;
	endtask

	// Lands mid-clock in the last clock of a CPU cycle
	task automatic end_of_cpu_cycle();
		@(negedge clk);
		while (!cpu_ce)
			@(negedge clk);
	endtask

	// Called right after reset falls, counts clocks from there
	task automatic enable_timing();
		for (int j = 0; j < 4 * cpu_div; j++) begin
			@(negedge clk);
			if (j == 0) begin                        // Quiet outputs straight out of reset
				check_value("reset pause_cpu", 16'(pause_cpu), 16'd0);
				check_value("reset dmc_ack", 16'(dmc_ack), 16'd0);
				check_value("reset bus_write", 16'(bus_write), 16'd0);
				check_value("reset joypad_clock", 16'(joypad_clock), 16'd0);
				check_value("reset joypad_out", 16'(joypad_out), 16'd0);
			end
			check_value("enables cpu_ce", 16'(cpu_ce), 16'(j % cpu_div == cpu_div - 1));
			check_value("enables ppu_ce", 16'(ppu_ce), 16'(j % ppu_div == ppu_div - 1));
			check_value("enables odd_cycle", 16'(odd_cycle), 16'((j / cpu_div) % 2 == 0));
		end
	endtask

	task automatic read_and_check(input string name, input logic [15:0] addr,
		input logic exp_apu, input logic exp_ppu, input logic [7:0] exp_din,
		input logic [1:0] exp_clock);
		next_drive_point();
		cpu_addr = addr;
		cpu_rnw = 1'b1;
		@(negedge clk);
		check_value({name, " bus_addr"}, bus_addr, addr);   // No DMA, CPU owns the bus
		check_value({name, " bus_read"}, 16'(bus_read), 16'd1);
		check_value({name, " apu_cs"}, 16'(apu_cs), 16'(exp_apu));
		check_value({name, " ppu_cs"}, 16'(ppu_cs), 16'(exp_ppu));
		check_value({name, " cpu_din"}, 16'(cpu_din), 16'(exp_din));
		check_value({name, " joypad_clock"}, 16'(joypad_clock), 16'(exp_clock));
	endtask

	task automatic decode_pass_through();
		next_drive_point();
		ppu_dout = 8'($urandom);
		apu_status = 8'($urandom);
		read_and_check("ram", 16'h0123, 1'b0, 1'b0, model_byte(16'h0123), 2'b00);
		read_and_check("ppu", 16'h2002, 1'b0, 1'b1, ppu_dout, 2'b00);
		read_and_check("ppu mirror", 16'h3ff9, 1'b0, 1'b1, ppu_dout, 2'b00);
		read_and_check("apu status", 16'h4015, 1'b1, 1'b0, apu_status, 2'b00);
		read_and_check("past apu", 16'h4018, 1'b0, 1'b0, model_byte(16'h4018), 2'b00);
		read_and_check("cart", 16'hc7e1, 1'b0, 1'b0, model_byte(16'hc7e1), 2'b00);
	endtask

	task automatic open_bus_and_joypads();
		logic [7:0] strobe;
		strobe = 8'($urandom) | 8'h01;   // Strobe bit set so the latch has to move
		next_drive_point();
		joypad1_data = 5'($urandom);
		joypad2_data = 5'($urandom);
		// 0xe5 leaves 3'b111 floating above the pad bits
		read_and_check("bus seed", 16'h00e5, 1'b0, 1'b0, 8'he5, 2'b00);
		read_and_check("open bus", 16'h4000, 1'b1, 1'b0, 8'he5, 2'b00);
		read_and_check("joypad 1", 16'h4016, 1'b1, 1'b0, {3'b111, joypad1_data}, 2'b01);
		read_and_check("joypad 2", 16'h4017, 1'b1, 1'b0, {3'b111, joypad2_data}, 2'b10);
		next_drive_point();
		cpu_addr = 16'h4016;
		cpu_rnw = 1'b0;
		cpu_dout = strobe;
		@(negedge clk);
		check_value("strobe bus_write", 16'(bus_write), 16'd1);
		@(negedge clk);                                    // Latch took one clock
		check_value("strobe joypad_out", 16'(joypad_out), 16'(strobe[2:0]));
		next_drive_point();
		cpu_addr = 16'h0000;
		cpu_rnw = 1'b1;
	endtask

	// dmc_at below zero means no DMC request during the copy
	task automatic sprite_dma_copy(input string name, input logic [7:0] page, input int dmc_at);
		int   writes;
		int   dmc_reads;
		logic ack_seen;
		writes = 0;
		dmc_reads = 0;
		next_drive_point();
		cpu_addr = 16'h4014;
		cpu_rnw = 1'b0;
		cpu_dout = page;
		end_of_cpu_cycle();
		next_drive_point();
		cpu_addr = 16'h0000;        // CPU parks on reads while paused
		cpu_rnw = 1'b1;
		@(negedge clk);
		check_value({name, " pause start"}, 16'(pause_cpu), 16'd1);
		while (writes < 256) begin
			end_of_cpu_cycle();
			ack_seen = dmc_ack;
			if (bus_write) begin
				check_value({name, " write addr"}, bus_addr, 16'h2004);
				check_value({name, " write data"}, 16'(bus_dout),
					16'(model_byte({page, 8'(writes)})));
				check_value({name, " pause"}, 16'(pause_cpu), 16'd1);
				writes++;
			end
			if (ack_seen) begin
				check_value({name, " dmc addr"}, bus_addr, dmc_addr);
				check_value({name, " dmc read"}, 16'(bus_read), 16'd1);
				check_value({name, " dmc data"}, 16'(cpu_din), 16'(model_byte(dmc_addr)));
				dmc_reads++;
			end
			next_drive_point();
			if (ack_seen)
				dmc_request = 1'b0;             // Sample channel got its byte
			if (writes == dmc_at && !dmc_request && dmc_reads == 0) begin
				dmc_addr = {4'hc, 12'($urandom)};
				dmc_request = 1'b1;
			end
		end
		@(negedge clk);
		check_value({name, " pause end"}, 16'(pause_cpu), 16'd0);
		check_value({name, " dmc reads"}, 16'(dmc_reads), (dmc_at >= 0) ? 16'd1 : 16'd0);
	endtask

	initial begin
		void'($urandom(32'hdaedd403));
		clk = 1'b0;
		reset = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		cpu_rnw = 1'b1;
		dmc_request = 1'b0;
		dmc_addr = 16'h0000;
		ppu_dout = 8'h00;
		apu_status = 8'h00;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		enable_timing();
		decode_pass_through();
		open_bus_and_joypads();
		sprite_dma_copy("sprite dma", 8'($urandom), -1);
		sprite_dma_copy("dmc interrupt", 8'($urandom), 40);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: tests still running after %0d CPU cycles", watchdog_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
